// File: source/regfile_pkg.sv
/*
  Geometry and word types of the banked integer register file.
  Modules import it inside their bodies and use scoped names in their port lists.
*/
`default_nettype none

package regfile_pkg;

  // register array geometry
  localparam int reg_count  = 64;
  localparam int data_width = 32;
  localparam int addr_width = $clog2(reg_count);

  // port counts
  localparam int num_read  = 4;
  localparam int num_write = 2;

  // banks are split on address bit 0, the upper bits select the row
  localparam int bank_count = 2;
  localparam int bank_depth = reg_count / bank_count;
  localparam int row_width  = addr_width - 1;

  // one register value
  typedef logic [data_width-1:0] reg_data_t;

  // full register address, bit 0 is the bank
  typedef logic [addr_width-1:0] reg_addr_t;

  // row inside one bank
  typedef logic [row_width-1:0] row_addr_t;

endpackage

`default_nettype wire

// File: source/regfile_init_pkg.sv
/*
  State encoding and limits of the zero sweep that runs after reset.
*/
`default_nettype none

package regfile_init_pkg;

  // sweep FSM states
  typedef enum logic {
    init_sweep,
    init_done
  } init_state_t;

  // final row written before the register file opens
  localparam regfile_pkg::row_addr_t init_last_row =
    regfile_pkg::row_addr_t'(regfile_pkg::bank_depth - 1);

endpackage

`default_nettype wire

// File: source/regfile_bank.sv
/*
  One register bank: two write ports and a registered row per read port.
  Read data is driven from storage in the cycle after the row is captured.
*/
`timescale 1ns/1ns
`default_nettype none

module regfile_bank (
  input  wire                                               clk,
  input  wire                                               rst,
  input  wire [regfile_pkg::num_write-1:0]                  wr_en,
  input  wire regfile_pkg::row_addr_t [regfile_pkg::num_write-1:0] wr_row,
  input  wire regfile_pkg::reg_data_t [regfile_pkg::num_write-1:0] wr_data,
  input  wire regfile_pkg::row_addr_t [regfile_pkg::num_read-1:0]  rd_row,
  output regfile_pkg::reg_data_t [regfile_pkg::num_read-1:0]       rd_data
);

  import regfile_pkg::*;

  reg_data_t mem [bank_depth];

  // read rows captured at every edge
  row_addr_t [num_read-1:0] rd_row_q;

  // ports are applied in order, so port 1 wins a collision on one row
  always_ff @(posedge clk) begin
    for (int w = 0; w < num_write; w++) begin
      if (wr_en[w]) begin
        mem[wr_row[w]] <= wr_data[w];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_row_q <= '0;
    end else begin
      rd_row_q <= rd_row;
    end
  end

  // storage is read after the edge, so writes committed at that edge are visible
  always_comb begin
    for (int r = 0; r < num_read; r++) begin
      rd_data[r] = mem[rd_row_q[r]];
    end
  end

endmodule

`default_nettype wire

// File: source/regfile_init_seq.sv
/*
  Zero sweep FSM. After reset it writes one row of both banks per cycle,
  then raises init_done, which the top level presents as ready.
*/
`timescale 1ns/1ns
`default_nettype none

module regfile_init_seq (
  input  wire                     clk,
  input  wire                     rst,
  output logic                    init_wen,
  output regfile_pkg::row_addr_t  init_row,
  output logic                    init_done
);

  import regfile_init_pkg::*;

  init_state_t state;

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= init_sweep;
      init_wen <= 1'b0;
      init_row <= '0;
    end else begin
      case (state)
        init_sweep: begin
          if (!init_wen) begin
            // first cycle out of reset, row 0 goes out next
            init_wen <= 1'b1;
          end else if (init_row == init_last_row) begin
            init_wen <= 1'b0;
            state    <= regfile_init_pkg::init_done;
          end else begin
            init_row <= init_row + 1'b1;
          end
        end
        default: begin
          init_wen <= 1'b0;
        end
      endcase
    end
  end

  // the port shares its name with the state value, hence the scoped name
  assign init_done = (state == regfile_init_pkg::init_done);

endmodule

`default_nettype wire

// File: source/regfile_bypass.sv
/*
  Output stage of one read port. Picks the bank named by the registered
  address, forwards staged writes the banks do not hold yet, and applies the constant.
*/
`timescale 1ns/1ns
`default_nettype none

module regfile_bypass (
  input  wire                                                       clk,
  input  wire                                                       rst,
  input  wire                                                       rd_fire,
  input  wire regfile_pkg::reg_addr_t                               rd_addr,
  input  wire                                                       rd_const_en,
  input  wire regfile_pkg::reg_data_t                               rd_const,
  input  wire regfile_pkg::reg_data_t [regfile_pkg::bank_count-1:0] bank_data,
  input  wire [regfile_pkg::num_write-1:0]                          stage_en,
  input  wire regfile_pkg::reg_addr_t [regfile_pkg::num_write-1:0]  stage_addr,
  input  wire regfile_pkg::reg_data_t [regfile_pkg::num_write-1:0]  stage_data,
  output logic                                                      rd_data_valid,
  output regfile_pkg::reg_data_t                                    rd_data
);

  import regfile_pkg::*;

  reg_addr_t addr_q;
  reg_data_t const_q;
  logic      const_en_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_data_valid <= 1'b0;
      const_en_q    <= 1'b0;
    end else begin
      rd_data_valid <= rd_fire;
      const_en_q    <= rd_const_en;
    end
  end

  always_ff @(posedge clk) begin
    addr_q  <= rd_addr;
    const_q <= rd_const;
  end

  // staged entries are the writes of the read's own edge
  always_comb begin
    rd_data = bank_data[addr_q[0]];
    for (int w = 0; w < num_write; w++) begin
      // higher port checked last and so takes priority
      if (stage_en[w] && stage_addr[w] == addr_q) begin
        rd_data = stage_data[w];
      end
    end
    if (const_en_q) begin
      rd_data = const_q;
    end
  end

endmodule

`default_nettype wire

// File: source/regfile.sv
/*
  Top of the 64 x 32 register file with four read and two write ports.
  Requests transfer when their valid and ready are high; read data follows one cycle later.
*/
`timescale 1ns/1ns
`default_nettype none

module regfile (
  input  wire                                                      clk,
  input  wire                                                      rst,
  output logic                                                     ready,
  input  wire [regfile_pkg::num_read-1:0]                          rd_valid,
  input  wire regfile_pkg::reg_addr_t [regfile_pkg::num_read-1:0]  rd_addr,
  input  wire [regfile_pkg::num_read-1:0]                          rd_const_en,
  input  wire regfile_pkg::reg_data_t [regfile_pkg::num_read-1:0]  rd_const,
  output logic [regfile_pkg::num_read-1:0]                         rd_data_valid,
  output regfile_pkg::reg_data_t [regfile_pkg::num_read-1:0]       rd_data,
  input  wire [regfile_pkg::num_write-1:0]                         wr_en,
  input  wire regfile_pkg::reg_addr_t [regfile_pkg::num_write-1:0] wr_addr,
  input  wire regfile_pkg::reg_data_t [regfile_pkg::num_write-1:0] wr_data
);

  import regfile_pkg::*;

  logic [num_read-1:0]  rd_fire;
  logic [num_write-1:0] wr_fire;

  // write stage, one cycle ahead of the banks
  logic [num_write-1:0]      stage_en;
  reg_addr_t [num_write-1:0] stage_addr;
  reg_data_t [num_write-1:0] stage_data;

  logic      init_wen;
  row_addr_t init_row;

  row_addr_t [num_read-1:0]                    rd_row;
  logic [bank_count-1:0][num_write-1:0]        bank_wen;
  row_addr_t [bank_count-1:0][num_write-1:0]   bank_wrow;
  reg_data_t [bank_count-1:0][num_write-1:0]   bank_wdata;
  reg_data_t [bank_count-1:0][num_read-1:0]    bank_rdata;
  reg_data_t [num_read-1:0][bank_count-1:0]    port_bank_data;

  assign rd_fire = rd_valid & {num_read{ready}};
  assign wr_fire = wr_en & {num_write{ready}};

  always_ff @(posedge clk) begin
    if (rst) begin
      stage_en <= '0;
    end else begin
      stage_en <= wr_fire;
    end
  end

  always_ff @(posedge clk) begin
    stage_addr <= wr_addr;
    stage_data <= wr_data;
  end

  regfile_init_seq init_seq (
    .clk       (clk),
    .rst       (rst),
    .init_wen  (init_wen),
    .init_row  (init_row),
    .init_done (ready)
  );

  // steer staged writes by bank bit; the sweep borrows port 0 of each bank
  always_comb begin
    for (int b = 0; b < bank_count; b++) begin
      for (int w = 0; w < num_write; w++) begin
        bank_wen[b][w]   = stage_en[w] && (stage_addr[w][0] == 1'(b));
        bank_wrow[b][w]  = stage_addr[w][addr_width-1:1];
        bank_wdata[b][w] = stage_data[w];
      end
      if (init_wen) begin
        bank_wen[b][0]   = 1'b1;
        bank_wrow[b][0]  = init_row;
        bank_wdata[b][0] = '0;
      end
    end
  end

  // both banks look up the same row, the bypass stage picks one
  always_comb begin
    for (int r = 0; r < num_read; r++) begin
      rd_row[r] = rd_addr[r][addr_width-1:1];
      for (int b = 0; b < bank_count; b++) begin
        port_bank_data[r][b] = bank_rdata[b][r];
      end
    end
  end

  for (genvar b = 0; b < bank_count; b++) begin : g_bank
    regfile_bank bank (
      .clk     (clk),
      .rst     (rst),
      .wr_en   (bank_wen[b]),
      .wr_row  (bank_wrow[b]),
      .wr_data (bank_wdata[b]),
      .rd_row  (rd_row),
      .rd_data (bank_rdata[b])
    );
  end

  for (genvar r = 0; r < num_read; r++) begin : g_read
    regfile_bypass bypass (
      .clk           (clk),
      .rst           (rst),
      .rd_fire       (rd_fire[r]),
      .rd_addr       (rd_addr[r]),
      .rd_const_en   (rd_const_en[r]),
      .rd_const      (rd_const[r]),
      .bank_data     (port_bank_data[r]),
      .stage_en      (stage_en),
      .stage_addr    (stage_addr),
      .stage_data    (stage_data),
      .rd_data_valid (rd_data_valid[r]),
      .rd_data       (rd_data[r])
    );
  end

endmodule

`default_nettype wire

// File: bench/tb_clock.sv
/*
  Clock and reset for the testbench. 20 ns period, reset high for the first 10 edges.
*/
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
  output logic clk,
  output logic rst
);

  localparam int half_period   = 10;
  localparam int reset_cycles  = 10;
  localparam int release_delay = 2;

  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  // reset drops a little after the edge, like every other stimulus
  initial begin
    rst = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    #release_delay rst = 1'b0;
  end

endmodule

`default_nettype wire

// File: bench/regfile_asserts.sv
/*
  Handshake and zero sweep checks, bound into the register file top level.
*/
`timescale 1ns/1ns
`default_nettype none

module regfile_asserts (
  input wire                                clk,
  input wire                                rst,
  input wire                                ready,
  input wire [regfile_pkg::num_read-1:0]    rd_valid,
  input wire [regfile_pkg::num_read-1:0]    rd_data_valid,
  input wire                                init_wen,
  input wire regfile_pkg::row_addr_t        init_row,
  input wire regfile_init_pkg::init_state_t state
);

  import regfile_pkg::*;
  import regfile_init_pkg::*;

  reset_closes_ready: assert property (@(posedge clk) rst |=> !ready)
    else $error("ready high in the cycle after reset");

  read_valid_latency: assert property (@(posedge clk) disable iff (rst)
    rd_data_valid == $past(rd_valid & {num_read{ready}}))
    else $error("rd_data_valid does not follow the read transfer by one cycle");

  ready_holds: assert property (@(posedge clk) disable iff (rst) !$fell(ready))
    else $error("ready fell while out of reset");

  // the sweep may only close right after writing its final row
  sweep_complete: assert property (@(posedge clk) disable iff (rst)
    $rose(state == init_done) |-> $past(init_wen && init_row == init_last_row))
    else $error("sweep finished before its last row");

endmodule

`default_nettype wire

// File: bench/regfile_tb.sv
/*
  Testbench of the register file. Random and directed requests run against a
  register model, and every read result is checked in the cycle after it transfers.
*/
`timescale 1ns/1ns
`default_nettype none

module regfile_tb;

  import regfile_pkg::*;

  localparam int drive_delay   = 2;
  localparam int ready_timeout = 200;

  logic                      clk, rst, ready;
  logic [num_read-1:0]       rd_valid, rd_const_en, rd_data_valid;
  reg_addr_t [num_read-1:0]  rd_addr;
  reg_data_t [num_read-1:0]  rd_const, rd_data;
  logic [num_write-1:0]      wr_en;
  reg_addr_t [num_write-1:0] wr_addr;
  reg_data_t [num_write-1:0] wr_data;

  reg_data_t                model [reg_count];
  logic [num_read-1:0]      exp_valid;
  reg_data_t [num_read-1:0] exp_data;
  logic                     ready_seen;
  logic [15:0]              lfsr_state;
  string                    test_name;
  int                       test_checks, test_errors;
  int                       total_checks, total_errors, test_count;

  tb_clock clock_gen (.clk(clk), .rst(rst));

  regfile uut (.*);

  bind regfile regfile_asserts asserts (.*, .state(init_seq.state));

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
  endfunction

  function automatic logic [31:0] rand_bits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      value      = {value[30:0], lfsr_state[0]};
    end
    return value;
  endfunction

  // writes of the same edge land before the read and port 1 goes last
  function automatic reg_data_t expected_read(input reg_addr_t addr, input logic const_en,
                                              input reg_data_t const_value);
    reg_data_t value;
    value = model[addr];
    for (int w = 0; w < num_write; w++) begin
      if (wr_en[w] && wr_addr[w] == addr) begin
        value = wr_data[w];
      end
    end
    return const_en ? const_value : value;
  endfunction

  task automatic check_data(input string what, input reg_data_t expected,
                            input reg_data_t actual);
    test_checks++;
    if (actual !== expected) begin
      test_errors++;
      $display("** Error %s %s: expected %h, actual %h", test_name, what, expected, actual);
    end
  endtask

  task automatic check_flag(input string what, input logic expected, input logic actual);
    test_checks++;
    if (actual !== expected) begin
      test_errors++;
      $display("** Error %s %s: expected %b, actual %b", test_name, what, expected, actual);
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #drive_delay;
  endtask

  task automatic random_request(input logic with_const);
    for (int r = 0; r < num_read; r++) begin
      rd_valid[r]    = 1'(rand_bits(1));
      rd_addr[r]     = reg_addr_t'(rand_bits(addr_width));
      rd_const_en[r] = with_const & 1'(rand_bits(1));
      rd_const[r]    = rand_bits(data_width);
    end
    for (int w = 0; w < num_write; w++) begin
      wr_en[w]   = 1'(rand_bits(1));
      wr_addr[w] = reg_addr_t'(rand_bits(addr_width));
      wr_data[w] = rand_bits(data_width);
    end
  endtask

  // requests keep coming while ready is low, all of them must be dropped
  task automatic wait_ready(output bit ok);
    int cycles;
    ok = 1'b0;
    for (cycles = 0; cycles < ready_timeout && !ok; cycles++) begin
      next_cycle();
      ok = (ready === 1'b1);
      if (!ok) begin
        random_request(1'b1);
      end
    end
  endtask

  // one register written, then read on every port for three cycles
  task automatic write_then_read(input logic [num_write-1:0] ports);
    random_request(1'b0);
    wr_en      = ports;
    wr_addr[1] = wr_addr[0];
    rd_valid   = '1;
    for (int r = 0; r < num_read; r++) begin
      rd_addr[r] = wr_addr[0];
    end
    next_cycle();
    wr_en = '0;
    next_cycle();
    next_cycle();
  endtask

  task automatic end_test();
    {rd_valid, rd_const_en, wr_en} = '0;
    next_cycle();
    next_cycle();
    $display("test %s: %0d checks, %0d errors", test_name, test_checks, test_errors);
    total_checks += test_checks;
    total_errors += test_errors;
    test_count++;
    test_checks = 0;
    test_errors = 0;
  endtask

  // results of the reads from the last edge, then the transfers of the coming edge
  always @(negedge clk) begin
    if (rst === 1'b0) begin
      // once open, the register file stays open until the next reset
      if (ready_seen) begin
        check_flag("ready", 1'b1, ready);
      end
      for (int r = 0; r < num_read; r++) begin
        check_flag($sformatf("rd_data_valid[%0d]", r), exp_valid[r], rd_data_valid[r]);
        if (exp_valid[r]) begin
          check_data($sformatf("rd_data[%0d]", r), exp_data[r], rd_data[r]);
        end
      end
    end
    ready_seen = ready_seen || (rst === 1'b0 && ready === 1'b1);
    for (int r = 0; r < num_read; r++) begin
      exp_valid[r] = rd_valid[r] && ready === 1'b1;
      exp_data[r]  = expected_read(rd_addr[r], rd_const_en[r], rd_const[r]);
    end
    for (int w = 0; w < num_write; w++) begin
      if (wr_en[w] && ready === 1'b1) begin
        model[wr_addr[w]] = wr_data[w];
      end
    end
  end

  initial begin
    bit ok;
    {rd_valid, rd_addr, rd_const_en, rd_const} = '0;
    {wr_en, wr_addr, wr_data} = '0;
    exp_valid  = '0;
    exp_data   = '0;
    ready_seen = 1'b0;
    model      = '{default: '0};
    lfsr_state = 16'd13;
    test_name  = "not_ready";
    wait_ready(ok);
    if (!ok) begin
      $display("ready stayed low for %0d cycles after reset", ready_timeout);
      $display("** FAIL **");
    end else begin
      end_test();
      test_name = "zero_sweep";
      rd_valid  = '1;
      for (int base = 0; base < reg_count; base += num_read) begin
        for (int r = 0; r < num_read; r++) begin
          rd_addr[r] = reg_addr_t'(base + r);
        end
        next_cycle();
      end
      end_test();
      test_name = "random_rw";
      repeat (60) begin
        random_request(1'b0);
        next_cycle();
      end
      end_test();
      test_name = "write_first";
      for (int i = 0; i < 6; i++) begin
        write_then_read((i % 2 == 0) ? 2'b01 : 2'b10);
      end
      end_test();
      test_name = "write_collide";
      repeat (6) begin
        write_then_read(2'b11);
      end
      end_test();
      // constants win even over a write to the same register
      test_name = "const_read";
      repeat (8) begin
        random_request(1'b1);
        {rd_valid, rd_const_en, wr_en} = '1;
        for (int r = 0; r < num_read; r++) begin
          rd_addr[r] = wr_addr[0];
        end
        next_cycle();
      end
      end_test();
      $display("%0d tests, %0d checks, %0d errors", test_count, total_checks, total_errors);
      if (total_errors == 0) begin
        $display("** PASS **");
      end else begin
        $display("** FAIL **");
      end
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
source/regfile_pkg.sv
source/regfile_init_pkg.sv
source/regfile_bank.sv
source/regfile_init_seq.sv
source/regfile_bypass.sv
source/regfile.sv
bench/tb_clock.sv
bench/regfile_asserts.sv
bench/regfile_tb.sv

// File: Makefile
# Verilator build and run of the register file testbench

VERILATOR := verilator
FLAGS     := --binary --timing --assert
TOP       := regfile_tb
FILELIST  := filelist.f
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := ** FAIL **

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -qF '$(FAIL_MSG)' $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
